//--- files.f
+incdir+hw
hw/i2cPkg.sv
hw/i2cBitEngine.sv
hw/i2cByteEngine.sv
hw/i2cTransactionSeq.sv
hw/i2cMasterTop.sv
tb/i2cSlaveModel.sv
tb/tbI2cMaster.sv

//--- run.sh
#!/bin/sh
# Build and run the I2C master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tbI2cMaster -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi

//--- tb/tbI2cMaster.sv
`timescale 1ns/1ps

module tbI2cMaster import i2cPkg::*; ();

    localparam int TimeoutCycles = 6 * 400;

    logic       FSM_Clk;
    logic       rstN;
    logic       cmdValid;
    i2cCmdT     cmd;
    logic       cmdReady;
    logic       rspValid;
    i2cRspT     rsp;
    logic       scl;
    logic       sdaLow;
    logic       slaveSdaLow;
    logic       sdaBus;
    integer     errors;
    integer     cycles;
    integer     seed;
    logic [7:0] shadow [0:127];

    // Wired-AND open-drain SDA
    assign sdaBus = !(sdaLow || slaveSdaLow);

    i2cMasterTop dut (
        .FSM_Clk  (FSM_Clk),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .cmdReady (cmdReady),
        .rspValid (rspValid),
        .rsp      (rsp),
        .scl      (scl),
        .sdaLow   (sdaLow),
        .sdaIn    (sdaBus)
    );

    i2cSlaveModel slave (
        .FSM_Clk (FSM_Clk),
        .rstN    (rstN),
        .scl     (scl),
        .sda     (sdaBus),
        .sdaLow  (slaveSdaLow)
    );

    always #4 FSM_Clk = !FSM_Clk;

    always @(posedge FSM_Clk) begin
        cycles = cycles + 1;
        if (cycles >= TimeoutCycles) begin
            $display("Timeout, no result after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic i2cCmdT makeCmd(input i2cOpE op, input logic [6:0] slaveAddr,
                                       input logic [6:0] subAddr, input logic [7:0] data,
                                       input i2cCountT count);
        i2cCmdT c;
        c.op        = op;
        c.slaveAddr = slaveAddr;
        c.subAddr   = subAddr;
        c.writeData = data;
        c.byteCount = count;
        return c;
    endfunction

    // Called 1 ns after a rising edge
    task automatic sendCommand(input i2cCmdT c);
        if (!cmdReady) begin
            $display("Controller busy, command could not be issued");
            errors = errors + 1;
        end
        cmdValid = 1'b1;
        cmd      = c;
        @(posedge FSM_Clk);
        #1;
        cmdValid = 1'b0;
    endtask

    task automatic waitResponse(output i2cRspT r);
        while (!rspValid) begin
            @(posedge FSM_Clk);
            #1;
        end
        r = rsp;
        @(posedge FSM_Clk);
        #1;
    endtask

    // **************************************************
    // Directed tests
    task automatic resetState();
        if (cmdReady !== 1'b1) begin
            $display("FAILED cmdReady got %h expected %h", cmdReady, 1'b1);
            errors = errors + 1;
        end
        if (rspValid !== 1'b0) begin
            $display("FAILED rspValid got %h expected %h", rspValid, 1'b0);
            errors = errors + 1;
        end
        if (scl !== 1'b1 || sdaLow !== 1'b0) begin
            $display("FAILED scl/sdaLow got %h/%h expected 1/0", scl, sdaLow);
            errors = errors + 1;
        end
    endtask

    task automatic singleWrite();
        logic [6:0] sub;
        logic [7:0] data;
        i2cRspT     r;
        sub  = 7'($random(seed));
        data = 8'($random(seed));
        sendCommand(makeCmd(OpWrite, 7'h1E, sub, data, 3'd1));
        waitResponse(r);
        shadow[sub] = data;
        if (slave.regs[sub] !== data) begin
            $display("FAILED regs[%h] got %h expected %h", sub, slave.regs[sub], data);
            errors = errors + 1;
        end
        if (r.ackError !== 1'b0) begin
            $display("FAILED ackError got %h expected %h", r.ackError, 1'b0);
            errors = errors + 1;
        end
    endtask

    task automatic burstRead(input logic [6:0] sub, input i2cCountT count);
        logic [31:0] expData;
        i2cRspT      r;
        expData = '0;
        for (int k = 0; k < int'(count); k++) begin
            expData[k*8 +: 8] = shadow[7'(sub + 7'(k))];
        end
        sendCommand(makeCmd(OpRead, 7'h1E, sub, 8'h00, count));
        waitResponse(r);
        if (r.readData !== expData) begin
            $display("FAILED readData got %h expected %h", r.readData, expData);
            errors = errors + 1;
        end
        if (r.ackError !== 1'b0) begin
            $display("FAILED ackError got %h expected %h", r.ackError, 1'b0);
            errors = errors + 1;
        end
    endtask

    task automatic wrongAddress();
        i2cRspT r;
        sendCommand(makeCmd(OpRead, 7'h2A, 7'h05, 8'h00, 3'd2));
        while (!rspValid) begin
            @(posedge FSM_Clk);
            #1;
        end
        if (scl !== 1'b1 || sdaLow !== 1'b0) begin
            $display("FAILED scl/sdaLow got %h/%h expected 1/0", scl, sdaLow);
            errors = errors + 1;
        end
        waitResponse(r);
        if (r.ackError !== 1'b1) begin
            $display("FAILED ackError got %h expected %h", r.ackError, 1'b1);
            errors = errors + 1;
        end
        if (r.readData !== 32'h0) begin
            $display("FAILED readData got %h expected %h", r.readData, 32'h0);
            errors = errors + 1;
        end
    endtask

    task automatic busyCommand();
        i2cRspT r;
        integer extra;
        extra = 0;
        sendCommand(makeCmd(OpWrite, 7'h1E, 7'h10, 8'hA5, 3'd1));
        // Second command offered for the whole first transaction
        cmdValid = 1'b1;
        cmd      = makeCmd(OpWrite, 7'h1E, 7'h20, 8'h3C, 3'd1);
        while (!rspValid) begin
            if (cmdReady !== 1'b0) begin
                $display("FAILED cmdReady got %h expected %h", cmdReady, 1'b0);
                errors = errors + 1;
            end
            @(posedge FSM_Clk);
            #1;
        end
        cmdValid = 1'b0;
        waitResponse(r);
        shadow[7'h10] = 8'hA5;
        // Longer than a whole write transaction
        for (int i = 0; i < 250; i++) begin
            if (rspValid) extra = extra + 1;
            @(posedge FSM_Clk);
            #1;
        end
        if (extra != 0) begin
            $display("Second command was taken while busy, %0d extra responses", extra);
            errors = errors + 1;
        end
        if (r.ackError !== 1'b0) begin
            $display("FAILED ackError got %h expected %h", r.ackError, 1'b0);
            errors = errors + 1;
        end
        if (slave.regs[7'h10] !== 8'hA5) begin
            $display("FAILED regs[10] got %h expected %h", slave.regs[7'h10], 8'hA5);
            errors = errors + 1;
        end
        if (slave.regs[7'h20] !== shadow[7'h20]) begin
            $display("FAILED regs[20] got %h expected %h", slave.regs[7'h20], shadow[7'h20]);
            errors = errors + 1;
        end
    endtask

    // **************************************************
    initial begin
        FSM_Clk  = 1'b0;
        rstN     = 1'b0;
        cmdValid = 1'b0;
        cmd      = '0;
        errors   = 0;
        cycles   = 0;
        seed     = 64;
        // Same sequence as the slave preload
        for (int i = 0; i < 128; i++) begin
            shadow[i] = 8'($random(seed));
        end
        repeat (10) @(posedge FSM_Clk);
        #1;
        rstN = 1'b1;
        @(posedge FSM_Clk);
        #1;
        resetState();
        singleWrite();
        burstRead(7'($random(seed)), 3'd1);
        burstRead(7'h40, 3'd4);
        wrongAddress();
        busyCommand();
        $display("Run complete, %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb/i2cSlaveModel.sv
`timescale 1ns/1ps

module i2cSlaveModel #(
    parameter logic [6:0] SlaveAddr = 7'h1E
) (
    input  logic FSM_Clk,
    input  logic rstN,
    input  logic scl,
    input  logic sda,
    output logic sdaLow
);

    // Register file, read by the testbench tasks
    logic [7:0] regs [0:127];

    logic       prevScl;
    logic       prevSda;
    logic       active;
    logic       addressed;
    logic       reading;
    logic       rwBit;
    logic       autoInc;
    logic       masterAcked;
    logic [3:0] bitCnt;
    logic [1:0] byteIdx;
    logic [7:0] shiftIn;
    logic [7:0] shiftOut;
    logic [6:0] regPtr;
    integer     seed;

    initial begin
        seed = 64;
        for (int i = 0; i < 128; i++) begin
            regs[i] = 8'($random(seed));
        end
    end

    // **************************************************
    // Bus follower, sampled on FSM_Clk
    always @(posedge FSM_Clk or negedge rstN) begin : slaveFsm
        logic [6:0] nextPtr;
        nextPtr = regPtr + 7'(autoInc);
        if (!rstN) begin
            prevScl   <= 1'b1;
            prevSda   <= 1'b1;
            active    <= 1'b0;
            addressed <= 1'b0;
            reading   <= 1'b0;
            sdaLow    <= 1'b0;
            bitCnt    <= '0;
            byteIdx   <= '0;
            regPtr    <= '0;
            autoInc   <= 1'b0;
        end else begin
            prevScl <= scl;
            prevSda <= sda;
            if (prevScl && scl && prevSda && !sda) begin
                // START or repeated START
                active  <= 1'b1;
                bitCnt  <= '0;
                byteIdx <= '0;
                reading <= 1'b0;
                sdaLow  <= 1'b0;
            end else if (prevScl && scl && !prevSda && sda) begin
                // STOP
                active    <= 1'b0;
                addressed <= 1'b0;
                reading   <= 1'b0;
                sdaLow    <= 1'b0;
            end else if (active && !prevScl && scl) begin
                if (bitCnt < 4'd8) begin
                    shiftIn <= {shiftIn[6:0], sda};
                end else begin
                    masterAcked <= !sda;
                end
                bitCnt <= bitCnt + 4'd1;
            end else if (active && prevScl && !scl) begin
                if (bitCnt == 4'd8) begin
                    if (reading) begin
                        sdaLow <= 1'b0;
                    end else if (byteIdx == 2'd0) begin
                        addressed <= (shiftIn[7:1] == SlaveAddr);
                        sdaLow    <= (shiftIn[7:1] == SlaveAddr);
                        rwBit     <= shiftIn[0];
                    end else if (addressed) begin
                        sdaLow <= 1'b1;
                        if (byteIdx == 2'd1) begin
                            regPtr  <= shiftIn[6:0];
                            autoInc <= shiftIn[7];
                        end else begin
                            regs[regPtr] <= shiftIn;
                            regPtr       <= nextPtr;
                        end
                    end
                end else if (bitCnt == 4'd9) begin
                    bitCnt  <= '0;
                    byteIdx <= (byteIdx == 2'd3) ? byteIdx : byteIdx + 2'd1;
                    if (addressed && byteIdx == 2'd0 && rwBit) begin
                        reading  <= 1'b1;
                        shiftOut <= regs[regPtr];
                        sdaLow   <= !regs[regPtr][7];
                    end else if (reading && masterAcked) begin
                        regPtr   <= nextPtr;
                        shiftOut <= regs[nextPtr];
                        sdaLow   <= !regs[nextPtr][7];
                    end else begin
                        reading <= 1'b0;
                        sdaLow  <= 1'b0;
                    end
                end else if (reading && bitCnt != 4'd0) begin
                    // Next data bit, MSB first
                    sdaLow <= !shiftOut[3'(4'd7 - bitCnt)];
                end
            end
        end
    end

endmodule

//--- hw/i2cMasterTop.sv
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2cMasterTop import i2cPkg::*; (
    input  logic   FSM_Clk,
    input  logic   rstN,
    input  logic   cmdValid,
    input  i2cCmdT cmd,
    output logic   cmdReady,
    output logic   rspValid,
    output i2cRspT rsp,
    output logic   scl,
    output logic   sdaLow,
    input  logic   sdaIn
);

    // **************************************************
    // Sequencer to byte engine
    logic                   byteStart;
    i2cBitOpE               byteOp;
    logic [`I2C_DATA_W-1:0] txByte;
    logic                   masterAck;
    logic                   byteDone;
    logic [`I2C_DATA_W-1:0] rxByte;
    logic                   slaveAck;

    i2cTransactionSeq seq (
        .FSM_Clk   (FSM_Clk),
        .rstN      (rstN),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .cmdReady  (cmdReady),
        .rspValid  (rspValid),
        .rsp       (rsp),
        .byteStart (byteStart),
        .byteOp    (byteOp),
        .txByte    (txByte),
        .masterAck (masterAck),
        .byteDone  (byteDone),
        .rxByte    (rxByte),
        .slaveAck  (slaveAck)
    );

    i2cByteEngine byteEngine (
        .FSM_Clk   (FSM_Clk),
        .rstN      (rstN),
        .byteStart (byteStart),
        .byteOp    (byteOp),
        .txByte    (txByte),
        .masterAck (masterAck),
        .sdaIn     (sdaIn),
        .byteDone  (byteDone),
        .rxByte    (rxByte),
        .slaveAck  (slaveAck),
        .scl       (scl),
        .sdaLow    (sdaLow)
    );

endmodule

//--- hw/i2cTransactionSeq.sv
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2cTransactionSeq import i2cPkg::*; (
    input  logic                   FSM_Clk,
    input  logic                   rstN,
    input  logic                   cmdValid,
    input  i2cCmdT                 cmd,
    output logic                   cmdReady,
    output logic                   rspValid,
    output i2cRspT                 rsp,
    output logic                   byteStart,
    output i2cBitOpE               byteOp,
    output logic [`I2C_DATA_W-1:0] txByte,
    output logic                   masterAck,
    input  logic                   byteDone,
    input  logic [`I2C_DATA_W-1:0] rxByte,
    input  logic                   slaveAck
);

    localparam int LaneW = $clog2(`I2C_MAX_BURST);

    typedef enum logic [3:0] {
        Idle,
        Start,
        SlaveAddrW,
        SubAddr,
        WriteData,
        Restart,
        SlaveAddrR,
        ReadData,
        Stop,
        Respond
    } seqStateE;

    seqStateE         state;
    i2cCmdT           cmdQ;
    logic             issued;
    i2cCountT         remaining;
    logic [LaneW-1:0] lane;

    logic             accept;
    logic             isTxState;
    logic             nack;
    logic             lastRead;

    assign cmdReady  = (state == Idle);
    assign rspValid  = (state == Respond);
    assign accept    = cmdValid && cmdReady;
    assign isTxState = state inside {SlaveAddrW, SubAddr, WriteData, SlaveAddrR};
    assign nack      = byteDone && isTxState && !slaveAck;
    assign lastRead  = (remaining <= i2cCountT'(1));

    // **************************************************
    // Byte engine request per state
    always_comb begin
        byteOp    = BitWrite;
        txByte    = '0;
        masterAck = 1'b0;
        case (state)
            Start, Restart: byteOp = BitStart;
            Stop:           byteOp = BitStop;
            SlaveAddrW:     txByte = {cmdQ.slaveAddr, 1'b0};
            // Bit 7 asks the slave to auto-increment
            SubAddr:        txByte = {(cmdQ.op == OpRead) && (cmdQ.byteCount > 1), cmdQ.subAddr};
            WriteData:      txByte = cmdQ.writeData;
            SlaveAddrR:     txByte = {cmdQ.slaveAddr, 1'b1};
            ReadData: begin
                byteOp    = BitRead;
                masterAck = !lastRead;
            end
            default: ;
        endcase
    end

    // **************************************************
    // Transaction FSM
    always_ff @(posedge FSM_Clk or negedge rstN) begin
        if (!rstN) begin
            state     <= Idle;
            issued    <= 1'b0;
            byteStart <= 1'b0;
            remaining <= '0;
            lane      <= '0;
        end else begin
            byteStart <= 1'b0;
            // One request per byte state entry
            if (state != Idle && state != Respond && !issued) begin
                byteStart <= 1'b1;
                issued    <= 1'b1;
            end
            if (byteDone) begin
                issued <= 1'b0;
            end
            case (state)
                Idle: begin
                    if (accept) begin
                        state     <= Start;
                        remaining <= cmd.byteCount;
                        lane      <= '0;
                    end
                end
                Start: begin
                    if (byteDone) state <= SlaveAddrW;
                end
                SlaveAddrW: begin
                    if (byteDone) begin
                        if (slaveAck) state <= SubAddr;
                        else state <= Stop;
                    end
                end
                SubAddr: begin
                    if (byteDone) begin
                        if (!slaveAck) state <= Stop;
                        else if (cmdQ.op == OpWrite) state <= WriteData;
                        else state <= Restart;
                    end
                end
                WriteData: begin
                    if (byteDone) state <= Stop;
                end
                Restart: begin
                    if (byteDone) state <= SlaveAddrR;
                end
                SlaveAddrR: begin
                    if (byteDone) begin
                        if (slaveAck) state <= ReadData;
                        else state <= Stop;
                    end
                end
                ReadData: begin
                    if (byteDone) begin
                        remaining <= remaining - 1'b1;
                        lane      <= lane + 1'b1;
                        if (lastRead) state <= Stop;
                    end
                end
                Stop: begin
                    if (byteDone) state <= Respond;
                end
                default: state <= Idle;
            endcase
        end
    end

    // Command latch and response assembly
    always_ff @(posedge FSM_Clk) begin
        if (accept) begin
            cmdQ <= cmd;
            rsp  <= '0;
        end
        if (nack) begin
            rsp.ackError <= 1'b1;
        end
        if (state == ReadData && byteDone) begin
            rsp.readData[lane*`I2C_DATA_W +: `I2C_DATA_W] <= rxByte;
        end
    end

endmodule

//--- hw/i2cByteEngine.sv
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2cByteEngine import i2cPkg::*; (
    input  logic                   FSM_Clk,
    input  logic                   rstN,
    input  logic                   byteStart,
    input  i2cBitOpE               byteOp,
    input  logic [`I2C_DATA_W-1:0] txByte,
    input  logic                   masterAck,
    input  logic                   sdaIn,
    output logic                   byteDone,
    output logic [`I2C_DATA_W-1:0] rxByte,
    output logic                   slaveAck,
    output logic                   scl,
    output logic                   sdaLow
);

    localparam int CntW = $clog2(`I2C_DATA_W + 1);
    localparam logic [CntW-1:0] LastData = CntW'(`I2C_DATA_W - 1);
    localparam logic [CntW-1:0] AckSlot = CntW'(`I2C_DATA_W);

    logic                   bitStart;
    i2cBitOpE               bitOp;
    logic                   txBit;
    logic                   bitDone;
    logic                   rxBit;

    logic                   active;
    logic                   framing;
    logic                   isRead;
    logic                   ackLow;
    logic [CntW-1:0]        bitCnt;
    logic [`I2C_DATA_W-1:0] shiftReg;
    logic                   accept;
    logic                   stepDone;

    assign accept   = byteStart && !active;
    assign stepDone = active && bitDone;

    i2cBitEngine bitEngine (
        .FSM_Clk  (FSM_Clk),
        .rstN     (rstN),
        .bitStart (bitStart),
        .bitOp    (bitOp),
        .txBit    (txBit),
        .sdaIn    (sdaIn),
        .bitDone  (bitDone),
        .rxBit    (rxBit),
        .scl      (scl),
        .sdaLow   (sdaLow)
    );

    // **************************************************
    // Bit sequencing, MSB first then the acknowledge slot
    always_ff @(posedge FSM_Clk or negedge rstN) begin
        if (!rstN) begin
            active   <= 1'b0;
            framing  <= 1'b0;
            bitCnt   <= '0;
            bitStart <= 1'b0;
            bitOp    <= BitStop;
            txBit    <= 1'b1;
            byteDone <= 1'b0;
        end else begin
            bitStart <= 1'b0;
            byteDone <= 1'b0;
            if (accept) begin
                active   <= 1'b1;
                framing  <= (byteOp == BitStart) || (byteOp == BitStop);
                bitCnt   <= '0;
                bitStart <= 1'b1;
                bitOp    <= byteOp;
                txBit    <= txByte[`I2C_DATA_W-1];
            end else if (stepDone) begin
                if (framing || bitCnt == AckSlot) begin
                    active   <= 1'b0;
                    byteDone <= 1'b1;
                end else begin
                    bitCnt   <= bitCnt + 1'b1;
                    bitStart <= 1'b1;
                    if (bitCnt == LastData) begin
                        // Ack direction is opposite to the data
                        if (isRead) begin
                            bitOp <= BitWrite;
                        end else begin
                            bitOp <= BitRead;
                        end
                        txBit <= !ackLow;
                    end else begin
                        txBit <= shiftReg[`I2C_DATA_W-2];
                    end
                end
            end
        end
    end

    // Shift register doubles as tx source and rx sink
    always_ff @(posedge FSM_Clk) begin
        if (accept) begin
            shiftReg <= txByte;
            isRead   <= (byteOp == BitRead);
            ackLow   <= masterAck;
        end else if (stepDone && !framing) begin
            if (bitCnt < AckSlot) begin
                shiftReg <= {shiftReg[`I2C_DATA_W-2:0], rxBit};
            end else begin
                slaveAck <= !rxBit;
            end
        end
    end

    assign rxByte = shiftReg;

endmodule

//--- hw/i2cBitEngine.sv
`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2cBitEngine import i2cPkg::*; (
    input  logic     FSM_Clk,
    input  logic     rstN,
    input  logic     bitStart,
    input  i2cBitOpE bitOp,
    input  logic     txBit,
    input  logic     sdaIn,
    output logic     bitDone,
    output logic     rxBit,
    output logic     scl,
    output logic     sdaLow
);

    localparam int PhaseW = $clog2(`I2C_BIT_PHASES);
    localparam logic [PhaseW-1:0] SamplePhase = PhaseW'(2);
    localparam logic [PhaseW-1:0] LastPhase = PhaseW'(`I2C_BIT_PHASES - 1);

    // Zero means idle, otherwise the next step to drive
    logic [PhaseW-1:0] phase;
    i2cBitOpE          opQ;
    logic              txQ;

    // **************************************************
    // Bus levels per step, {scl, sdaLow}
    function automatic logic [1:0] busLevels(
        input i2cBitOpE          op,
        input logic [PhaseW-1:0] step,
        input logic              bitVal
    );
        logic sclLvl;
        logic lowLvl;
        sclLvl = 1'b0;
        lowLvl = 1'b0;
        case (op)
            BitStart: begin
                case (int'(step))
                    0: begin sclLvl = 1'b0; lowLvl = 1'b0; end
                    1: begin sclLvl = 1'b1; lowLvl = 1'b0; end
                    2: begin sclLvl = 1'b1; lowLvl = 1'b1; end
                    default: begin sclLvl = 1'b0; lowLvl = 1'b1; end
                endcase
            end
            BitStop: begin
                case (int'(step))
                    0: begin sclLvl = 1'b0; lowLvl = 1'b1; end
                    1: begin sclLvl = 1'b1; lowLvl = 1'b1; end
                    default: begin sclLvl = 1'b1; lowLvl = 1'b0; end
                endcase
            end
            default: begin
                // Data bit, SCL pulses high in the middle two steps
                sclLvl = (int'(step) == 1) || (int'(step) == 2);
                lowLvl = (op == BitWrite) && !bitVal;
            end
        endcase
        return {sclLvl, lowLvl};
    endfunction

    always_ff @(posedge FSM_Clk or negedge rstN) begin
        if (!rstN) begin
            phase  <= '0;
            scl    <= 1'b1;
            sdaLow <= 1'b0;
        end else if (phase == '0) begin
            if (bitStart) begin
                {scl, sdaLow} <= busLevels(bitOp, '0, txBit);
                phase         <= PhaseW'(1);
            end
        end else begin
            {scl, sdaLow} <= busLevels(opQ, phase, txQ);
            phase         <= (phase == LastPhase) ? '0 : phase + 1'b1;
        end
    end

    // Op latch and SDA sample while SCL is high
    always_ff @(posedge FSM_Clk) begin
        if (phase == '0 && bitStart) begin
            opQ <= bitOp;
            txQ <= txBit;
        end
        if (phase == SamplePhase) begin
            rxBit <= sdaIn;
        end
    end

    assign bitDone = (phase == LastPhase);

endmodule

//--- hw/i2cPkg.sv
`include "i2c_defs.svh"

package i2cPkg;

    // Transaction direction
    typedef enum logic {
        OpWrite,
        OpRead
    } i2cOpE;

    // Single bus operation of the bit engine
    typedef enum logic [1:0] {
        BitStart,
        BitStop,
        BitWrite,
        BitRead
    } i2cBitOpE;

    // Read burst length, 1 to I2C_MAX_BURST
    typedef logic [$clog2(`I2C_MAX_BURST + 1)-1:0] i2cCountT;

    // **************************************************
    // Host command
    typedef struct packed {
        i2cOpE                  op;
        logic [`I2C_ADDR_W-1:0] slaveAddr;
        logic [`I2C_ADDR_W-1:0] subAddr;
        logic [`I2C_DATA_W-1:0] writeData;
        i2cCountT               byteCount;
    } i2cCmdT;

    // **************************************************
    // Response, first byte read in the low lane
    typedef struct packed {
        logic [`I2C_MAX_BURST*`I2C_DATA_W-1:0] readData;
        logic                                  ackError;
    } i2cRspT;

endpackage

//--- hw/i2c_defs.svh
`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// **************************************************
// Bus timing
// FSM_Clk cycles per bit, start or stop
`define I2C_BIT_PHASES 4

// **************************************************
// Field widths
`define I2C_ADDR_W 7
`define I2C_DATA_W 8

// Largest read burst in bytes
`define I2C_MAX_BURST 4

`endif
